/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_riscv_core
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
PASS_MSG  ?= ALL CHECKS PASSED

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* build.f */
hdl/riscv_pkg.sv
hdl/riscv_pipe_reg.sv
hdl/riscv_fstage.sv
hdl/riscv_dstage.sv
hdl/riscv_estage.sv
hdl/riscv_wbstage.sv
hdl/riscv_hazard.sv
hdl/riscv_core.sv
dv/tb_riscv_core.sv

/* dv/tb_riscv_core.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_riscv_core;

  typedef struct packed {
    riscv_pkg::reg_addr_t rd;
    riscv_pkg::xlen_t     data;
  } wr_exp_t;

  typedef struct packed {
    riscv_pkg::xlen_t addr;
    riscv_pkg::xlen_t data;   // only the strobed lanes
    logic [7:0]       strb;
  } st_exp_t;

  logic                 clk;
  logic                 arst_n;
  riscv_pkg::xlen_t     imem_addr, dmem_addr, dmem_wdata, dmem_rdata, wb_data;
  riscv_pkg::inst_t     imem_inst;
  logic [7:0]           dmem_wstrb;
  logic                 dmem_we, wb_valid;
  riscv_pkg::reg_addr_t wb_rd;

  riscv_pkg::inst_t rom [256];
  riscv_pkg::xlen_t dmem [64];
  riscv_pkg::xlen_t ref_mem [64];
  riscv_pkg::xlen_t ref_regs [32];
  riscv_pkg::inst_t halt;
  wr_exp_t          exp_wr[$];
  st_exp_t          exp_st[$];
  wr_exp_t          ew;
  st_exp_t          es;
  logic [31:0]      lfsr;
  int               prog_len;
  int               limit;
  int               cycles = 0;

  riscv_core uut (
    .i_riscv_core_clk (clk),
    .i_arst_n         (arst_n),
    .o_imem_addr      (imem_addr),
    .i_imem_inst      (imem_inst),
    .o_dmem_addr      (dmem_addr),
    .o_dmem_wdata     (dmem_wdata),
    .o_dmem_wstrb     (dmem_wstrb),
    .o_dmem_we        (dmem_we),
    .i_dmem_rdata     (dmem_rdata),
    .o_wb_valid       (wb_valid),
    .o_wb_rd          (wb_rd),
    .o_wb_data        (wb_data)
  );

  always #4 clk = ~clk;

  assign imem_inst  = rom[imem_addr[9:2]];
  assign dmem_rdata = dmem[dmem_addr[8:3]];

  always @(posedge clk) begin
    if (dmem_we) begin
      for (int k = 0; k < 8; k++) begin
        if (dmem_wstrb[k]) begin
          dmem[dmem_addr[8:3]][k*8 +: 8] <= dmem_wdata[k*8 +: 8];
        end
      end
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
  end

  // 32-bit fibonacci lfsr with taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int k = 0; k < n; k++) begin
      lfsr = lfsr_next(lfsr);
      v = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  function automatic riscv_pkg::reg_addr_t pick_reg();
    return riscv_pkg::reg_addr_t'(5'd8 + 5'(rand_bits(4)));  // x8..x23
  endfunction

  function automatic riscv_pkg::xlen_t lane_mask(input logic [7:0] strb);
    riscv_pkg::xlen_t m;
    for (int k = 0; k < 8; k++) begin
      m[k*8 +: 8] = {8{strb[k]}};
    end
    return m;
  endfunction

  function automatic riscv_pkg::inst_t enc_i(input logic [6:0] opc, input logic [2:0] f3,
      input riscv_pkg::reg_addr_t rd, rs1, input logic [11:0] imm);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic riscv_pkg::inst_t enc_r(input logic sub, input logic [2:0] f3,
      input riscv_pkg::reg_addr_t rd, rs1, rs2);
    return {1'b0, sub, 5'b0, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic riscv_pkg::inst_t enc_s(input logic [2:0] f3,
      input riscv_pkg::reg_addr_t rs1, rs2, input logic [11:0] imm);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
  endfunction

  function automatic riscv_pkg::inst_t enc_b(input logic [2:0] f3,
      input riscv_pkg::reg_addr_t rs1, rs2, input logic [12:0] off);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
  endfunction

  function automatic riscv_pkg::inst_t enc_j(input riscv_pkg::reg_addr_t rd,
      input logic [20:0] off);
    return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
  endfunction

  function automatic riscv_pkg::inst_t alu_inst(input logic [3:0] op,
      input riscv_pkg::reg_addr_t rd, rs1, rs2, input logic [11:0] imm);
    logic [11:0] sh;
    sh = {6'b0, imm[5:0]};
    case (op)
      4'd0:  return {imm, rs1, rs2[2:0], rd, 7'b0110111};  // lui with random upper bits
      4'd1:  return enc_i(riscv_pkg::OPC_OP_IMM, 3'b000, rd, rs1, imm);
      4'd2:  return enc_i(riscv_pkg::OPC_OP_IMM, 3'b111, rd, rs1, imm);
      4'd3:  return enc_i(riscv_pkg::OPC_OP_IMM, 3'b110, rd, rs1, imm);
      4'd4:  return enc_i(riscv_pkg::OPC_OP_IMM, 3'b100, rd, rs1, imm);
      4'd5:  return enc_i(riscv_pkg::OPC_OP_IMM, 3'b010, rd, rs1, imm);
      4'd6:  return enc_i(riscv_pkg::OPC_OP_IMM, 3'b001, rd, rs1, sh);
      4'd7:  return enc_i(riscv_pkg::OPC_OP_IMM, 3'b101, rd, rs1, sh);
      4'd8:  return enc_r(1'b0, 3'b000, rd, rs1, rs2);
      4'd9:  return enc_r(1'b1, 3'b000, rd, rs1, rs2);
      4'd10: return enc_r(1'b0, 3'b111, rd, rs1, rs2);
      4'd11: return enc_r(1'b0, 3'b110, rd, rs1, rs2);
      4'd12: return enc_r(1'b0, 3'b100, rd, rs1, rs2);
      4'd13: return enc_r(1'b0, 3'b010, rd, rs1, rs2);
      4'd14: return enc_r(1'b0, 3'b001, rd, rs1, rs2);
      default: return enc_r(1'b0, 3'b101, rd, rs1, rs2);
    endcase
  endfunction

  task automatic emit(input riscv_pkg::inst_t inst);
    rom[prog_len] = inst;
    prog_len++;
  endtask

  task automatic build_program();
    riscv_pkg::reg_addr_t r1, r2, rd, nd;
    logic [2:0]           sel, bo;
    logic [3:0]           dw;
    logic [11:0]          off;
    r1 = pick_reg();
    r2 = pick_reg();
    emit(enc_i(riscv_pkg::OPC_OP_IMM, 3'b000, 5'd2, 5'd0, 12'd256));  // x2 is the data base
    emit(alu_inst(4'd0, r1, r2, r1, 12'(rand_bits(12))));
    // every alu op in turn with each result feeding the next
    for (int n = 0; n < 24; n++) begin
      rd = pick_reg();
      emit(alu_inst(4'(n), rd, r1, r2, 12'(rand_bits(12))));
      r2 = r1;
      r1 = rd;
    end
    for (int n = 0; n < 20; n++) begin
      sel = 3'(n);
      dw  = 4'(rand_bits(4));
      bo  = 3'(rand_bits(3));
      rd  = pick_reg();
      off = {{5{dw[3]}}, dw, 3'b000};  // signed doubleword step around the base
      case (sel)
        3'd0: emit(enc_s(3'b011, 5'd2, r1, off));
        3'd1: emit(enc_s(3'b010, 5'd2, r1, off | {9'b0, bo[2], 2'b00}));
        3'd2, 3'd3: emit(enc_i(riscv_pkg::OPC_LOAD, {sel[0], 2'b00}, rd, 5'd2,
                               off | {9'b0, bo}));
        3'd4, 3'd5: emit(enc_i(riscv_pkg::OPC_LOAD, {sel[0], 2'b10}, rd, 5'd2,
                               off | {9'b0, bo[2], 2'b00}));
        default: emit(enc_i(riscv_pkg::OPC_LOAD, 3'b011, rd, 5'd2, off));
      endcase
      if (sel > 3'd1) begin
        nd = pick_reg();
        emit(enc_r(1'b0, 3'b000, nd, rd, r1));  // load result used at once
        r2 = rd;
        r1 = nd;
      end
    end
    repeat (3) begin
      rd = pick_reg();
      while (rd == r2) begin
        rd = pick_reg();
      end
      emit(enc_i(riscv_pkg::OPC_OP_IMM, 3'b000, rd, r1, 12'(rand_bits(12))));
      emit(enc_b(3'b000, rd, rd, 13'd12));                          // beq taken
      emit(enc_i(riscv_pkg::OPC_OP_IMM, 3'b000, r1, 5'd0, 12'd1));  // wrong path
      emit(enc_i(riscv_pkg::OPC_OP_IMM, 3'b000, r2, 5'd0, 12'd2));  // wrong path
      emit(enc_b(3'b001, rd, rd, 13'd8));                           // bne not taken
      emit(enc_i(riscv_pkg::OPC_OP_IMM, 3'b100, r2, rd, {11'(rand_bits(11)), 1'b1}));
      emit(enc_b(3'b000, rd, r2, 13'd8));                           // operands differ
      emit(enc_i(riscv_pkg::OPC_OP_IMM, 3'b000, r1, r1, 12'd3));
      emit(enc_b(3'b001, rd, r2, 13'd8));
      emit(enc_i(riscv_pkg::OPC_OP_IMM, 3'b000, r1, 5'd0, 12'd5));  // skipped
      emit(enc_j(5'd1, 21'd12));
      emit(enc_i(riscv_pkg::OPC_OP_IMM, 3'b000, r1, 5'd0, 12'd7));
      emit(enc_i(riscv_pkg::OPC_OP_IMM, 3'b000, r2, 5'd0, 12'd9));
      emit(enc_r(1'b0, 3'b000, r2, 5'd1, rd));  // link value right after the jump
      r1 = rd;
    end
    // x0 is never written and always reads zero
    emit(enc_i(riscv_pkg::OPC_OP_IMM, 3'b000, 5'd0, r1, 12'(rand_bits(12))));
    emit(enc_r(1'b0, 3'b000, r2, 5'd0, r1));
    emit({20'(rand_bits(20)), 5'd0, 7'b0110111});
    emit(enc_r(1'b0, 3'b110, r1, 5'd0, 5'd0));
    emit(halt);
  endtask

  function automatic riscv_pkg::xlen_t alu_ref(input logic [2:0] f3, input logic sub,
      input riscv_pkg::xlen_t a, b);
    case (f3)
      3'b000:  return sub ? a - b : a + b;
      3'b001:  return a << b[5:0];
      3'b010:  return ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
      3'b100:  return a ^ b;
      3'b101:  return a >> b[5:0];
      3'b110:  return a | b;
      default: return a & b;
    endcase
  endfunction

  // steps one instruction on the model state and returns the next pc
  function automatic riscv_pkg::xlen_t ref_step(input riscv_pkg::xlen_t pc,
      input riscv_pkg::inst_t in);
    riscv_pkg::xlen_t a, b, ii, is, ib, ij, res, addr, data, nxt;
    logic [2:0]       f3;
    logic [7:0]       strb;
    logic             wr;
    a   = ref_regs[in[19:15]];
    b   = ref_regs[in[24:20]];
    f3  = in[14:12];
    ii  = {{52{in[31]}}, in[31:20]};
    is  = {{52{in[31]}}, in[31:25], in[11:7]};
    ib  = {{52{in[31]}}, in[7], in[30:25], in[11:8], 1'b0};
    ij  = {{44{in[31]}}, in[19:12], in[20], in[30:21], 1'b0};
    nxt = pc + 64'd4;
    wr  = 1'b1;
    res = '0;
    case (in[6:0])
      riscv_pkg::OPC_LUI: res = {{32{in[31]}}, in[31:12], 12'b0};
      riscv_pkg::OPC_OP_IMM, riscv_pkg::OPC_OP: res = alu_ref(f3, in[5] && in[30], a,
                                                               in[5] ? b : ii);
      riscv_pkg::OPC_LOAD: begin
        addr = a + ii;
        res  = ref_mem[addr[8:3]] >> {addr[2:0], 3'b000};
        case (f3)
          3'b000:  res = {{56{res[7]}}, res[7:0]};
          3'b100:  res = {56'b0, res[7:0]};
          3'b010:  res = {{32{res[31]}}, res[31:0]};
          3'b110:  res = {32'b0, res[31:0]};
          default: res = res;
        endcase
      end
      riscv_pkg::OPC_STORE: begin
        wr   = 1'b0;
        addr = a + is;
        strb = (f3 == 3'b011) ? 8'hff : 8'h0f << addr[2:0];
        data = (b << {addr[2:0], 3'b000}) & lane_mask(strb);
        for (int k = 0; k < 8; k++) begin
          if (strb[k]) begin
            ref_mem[addr[8:3]][k*8 +: 8] = data[k*8 +: 8];
          end
        end
        exp_st.push_back(st_exp_t'{addr: {addr[63:3], 3'b000}, data: data, strb: strb});
      end
      riscv_pkg::OPC_BRANCH: begin
        wr = 1'b0;
        if ((a == b) != f3[0]) begin
          nxt = pc + ib;
        end
      end
      riscv_pkg::OPC_JAL: begin
        res = pc + 64'd4;
        nxt = pc + ij;
      end
      default: wr = 1'b0;
    endcase
    if (wr && in[11:7] != 5'd0) begin
      ref_regs[in[11:7]] = res;
      exp_wr.push_back(wr_exp_t'{rd: in[11:7], data: res});
    end
    return nxt;
  endfunction

  task automatic run_reference();
    riscv_pkg::xlen_t pc;
    pc = riscv_pkg::RESET_PC;
    for (int n = 0; n < 1024; n++) begin
      if (rom[pc[9:2]] == halt) begin
        break;
      end
      pc = ref_step(pc, rom[pc[9:2]]);
    end
  endtask

  task automatic stop_fail(input string why);
    $display("%s", why);
    $display("CHECKS FAILED");
    $fatal(1);
  endtask

  task automatic check_rd(input string name, input riscv_pkg::reg_addr_t got, exp);
    if (got !== exp) begin
      stop_fail($sformatf("error t=%0t %s got %0d expected %0d", $time, name, got, exp));
    end
  endtask

  task automatic check_xlen(input string name, input riscv_pkg::xlen_t got, exp);
    if (got !== exp) begin
      stop_fail($sformatf("error t=%0t %s got %h expected %h", $time, name, got, exp));
    end
  endtask

  task automatic check_strb(input string name, input logic [7:0] got, exp);
    if (got !== exp) begin
      stop_fail($sformatf("error t=%0t %s got %h expected %h", $time, name, got, exp));
    end
  endtask

  // outputs settle well before the falling edge
  always @(negedge clk) begin
    if (wb_valid) begin
      if (exp_wr.size() == 0) begin
        stop_fail($sformatf("register write to x%0d at %0t with none expected", wb_rd, $time));
      end else begin
        ew = exp_wr.pop_front();
        check_rd("o_wb_rd", wb_rd, ew.rd);
        check_xlen("o_wb_data", wb_data, ew.data);
      end
    end
  end

  always @(negedge clk) begin
    if (dmem_we) begin
      if (exp_st.size() == 0) begin
        stop_fail($sformatf("memory write at %0t with no store expected", $time));
      end else begin
        es = exp_st.pop_front();
        check_xlen("o_dmem_addr", dmem_addr, es.addr);
        check_strb("o_dmem_wstrb", dmem_wstrb, es.strb);
        check_xlen("o_dmem_wdata", dmem_wdata & lane_mask(es.strb), es.data);
      end
    end
  end

  initial begin
    clk      = 1'b0;
    arst_n   = 1'b0;
    lfsr     = 32'hdae1;
    prog_len = 0;
    halt     = enc_j(5'd0, 21'd0);  // jal x0, 0 spins in place
    for (int i = 0; i < 256; i++) begin
      rom[i] = halt;
    end
    for (int i = 0; i < 64; i++) begin
      dmem[i]    = riscv_pkg::xlen_t'(i + 1) * 64'h9e37_79b9_7f4a_7c15;
      ref_mem[i] = dmem[i];
    end
    for (int i = 0; i < 32; i++) begin
      ref_regs[i] = '0;
    end
    build_program();
    run_reference();
    limit = 3 * prog_len + 50;
    repeat (3) @(posedge clk);
    check_xlen("o_imem_addr", imem_addr, riscv_pkg::RESET_PC);  // pc held at its reset value
    #1 arst_n = 1'b1;
    while ((exp_wr.size() != 0 || exp_st.size() != 0) && cycles < limit) begin
      @(posedge clk);
    end
    repeat (10) @(posedge clk);  // idle time to catch stray writes
    if (exp_wr.size() != 0 || exp_st.size() != 0) begin
      stop_fail($sformatf("timeout after %0d cycles, %0d writes and %0d stores missing",
                          cycles, exp_wr.size(), exp_st.size()));
    end else begin
      $display("ALL CHECKS PASSED");
      $finish;
    end
  end

endmodule

`default_nettype wire

/* hdl/riscv_core.sv */
`timescale 1ns/100ps
`default_nettype none

module riscv_core (
  input  wire logic                 i_riscv_core_clk,
  input  wire logic                 i_arst_n,
  output riscv_pkg::xlen_t          o_imem_addr,
  input  wire riscv_pkg::inst_t     i_imem_inst,
  output riscv_pkg::xlen_t          o_dmem_addr,
  output riscv_pkg::xlen_t          o_dmem_wdata,
  output logic [7:0]                o_dmem_wstrb,
  output logic                      o_dmem_we,
  input  wire riscv_pkg::xlen_t     i_dmem_rdata,
  output logic                      o_wb_valid,
  output riscv_pkg::reg_addr_t      o_wb_rd,
  output riscv_pkg::xlen_t          o_wb_data
);

  riscv_pkg::fd_t       fd_d, fd_q;
  riscv_pkg::de_t       de_d, de_q;
  riscv_pkg::em_t       em_d, em_q;
  riscv_pkg::mw_t       mw_d, mw_q;
  riscv_pkg::xlen_t     target, m_result;
  riscv_pkg::reg_addr_t d_rs1, d_rs2;
  riscv_pkg::fwd_sel_e  fwd_a, fwd_b;
  logic                 redirect, stall_f, flush_fd, flush_de;
  logic [2:0]           byte_off;

  riscv_fstage u_riscv_fstage (
    .i_riscv_fstage_clk (i_riscv_core_clk),
    .i_arst_n           (i_arst_n),
    .i_stall            (stall_f),
    .i_redirect         (redirect),
    .i_target           (target),
    .i_inst             (i_imem_inst),
    .o_pc               (o_imem_addr),
    .o_fd               (fd_d)
  );

  riscv_pipe_reg #(.payload_t(riscv_pkg::fd_t)) u_fd_reg (
    .i_riscv_pipe_reg_clk (i_riscv_core_clk), .i_arst_n (i_arst_n),
    .i_en (!stall_f), .i_flush (flush_fd), .i_d (fd_d), .o_q (fd_q)
  );

  riscv_dstage u_riscv_dstage (
    .i_riscv_dstage_clk (i_riscv_core_clk),
    .i_arst_n           (i_arst_n),
    .i_fd               (fd_q),
    .i_wb_we            (o_wb_valid),
    .i_wb_rd            (o_wb_rd),
    .i_wb_data          (o_wb_data),
    .o_rs1              (d_rs1),
    .o_rs2              (d_rs2),
    .o_de               (de_d)
  );

  riscv_pipe_reg #(.payload_t(riscv_pkg::de_t)) u_de_reg (
    .i_riscv_pipe_reg_clk (i_riscv_core_clk), .i_arst_n (i_arst_n),
    .i_en (1'b1), .i_flush (flush_de), .i_d (de_d), .o_q (de_q)
  );

  // jal in memory forwards its link address, not the alu sum
  assign m_result = (em_q.ctrl.result_src == riscv_pkg::RES_PC4) ? em_q.pc_plus4 : em_q.result;

  riscv_estage u_riscv_estage (
    .i_de       (de_q),
    .i_fwd_a    (fwd_a),
    .i_fwd_b    (fwd_b),
    .i_m_result (m_result),
    .i_w_result (o_wb_data),
    .o_em       (em_d),
    .o_redirect (redirect),
    .o_target   (target)
  );

  riscv_pipe_reg #(.payload_t(riscv_pkg::em_t)) u_em_reg (
    .i_riscv_pipe_reg_clk (i_riscv_core_clk), .i_arst_n (i_arst_n),
    .i_en (1'b1), .i_flush (1'b0), .i_d (em_d), .o_q (em_q)
  );

  // memory stage, doubleword-aligned port with byte lanes
  assign byte_off     = em_q.result[2:0];
  assign o_dmem_addr  = {em_q.result[riscv_pkg::XLEN-1:3], 3'b000};
  assign o_dmem_wdata = em_q.store_data << {byte_off, 3'b000};
  assign o_dmem_we    = em_q.valid && em_q.ctrl.mem_write;

  always_comb begin
    case (em_q.ctrl.mem_size)
      riscv_pkg::MEM_B: o_dmem_wstrb = 8'h01 << byte_off;
      riscv_pkg::MEM_W: o_dmem_wstrb = 8'h0f << byte_off;
      default:          o_dmem_wstrb = 8'hff;
    endcase
  end

  assign mw_d = '{valid: em_q.valid, result: em_q.result, load_raw: i_dmem_rdata,
                  byte_off: byte_off, pc_plus4: em_q.pc_plus4, rd: em_q.rd,
                  ctrl: em_q.ctrl};

  riscv_pipe_reg #(.payload_t(riscv_pkg::mw_t)) u_mw_reg (
    .i_riscv_pipe_reg_clk (i_riscv_core_clk), .i_arst_n (i_arst_n),
    .i_en (1'b1), .i_flush (1'b0), .i_d (mw_d), .o_q (mw_q)
  );

  riscv_wbstage u_riscv_wbstage (
    .i_mw   (mw_q),
    .o_we   (o_wb_valid),
    .o_rd   (o_wb_rd),
    .o_data (o_wb_data)
  );

  riscv_hazard u_riscv_hazard (
    .i_d_rs1       (d_rs1),
    .i_d_rs2       (d_rs2),
    .i_e_rs1       (de_q.rs1),
    .i_e_rs2       (de_q.rs2),
    .i_e_rd        (de_q.rd),
    .i_m_rd        (em_q.rd),
    .i_w_rd        (o_wb_rd),
    .i_e_mem_read  (de_q.ctrl.mem_read),
    .i_m_reg_write (em_q.valid && em_q.ctrl.reg_write),
    .i_w_reg_write (o_wb_valid),
    .i_redirect    (redirect),
    .o_fwd_a       (fwd_a),
    .o_fwd_b       (fwd_b),
    .o_stall_f     (stall_f),
    .o_flush_fd    (flush_fd),
    .o_flush_de    (flush_de)
  );

endmodule

`default_nettype wire

/* hdl/riscv_dstage.sv */
`timescale 1ns/100ps
`default_nettype none

module riscv_dstage (
  input  wire logic                 i_riscv_dstage_clk,
  input  wire logic                 i_arst_n,
  input  wire riscv_pkg::fd_t       i_fd,
  input  wire logic                 i_wb_we,
  input  wire riscv_pkg::reg_addr_t i_wb_rd,
  input  wire riscv_pkg::xlen_t     i_wb_data,
  output riscv_pkg::reg_addr_t      o_rs1,
  output riscv_pkg::reg_addr_t      o_rs2,
  output riscv_pkg::de_t            o_de
);

  riscv_pkg::xlen_t   regs [riscv_pkg::NUM_REGS];
  riscv_pkg::inst_t   inst;
  riscv_pkg::ctrl_t   ctrl;
  riscv_pkg::xlen_t   imm;
  riscv_pkg::mem_size_e size;
  logic [2:0]         funct3;
  logic               known, use_rs1, use_rs2;

  // register-register and register-immediate share the funct3 map
  function automatic riscv_pkg::alu_op_e alu_sel(input logic [2:0] f3, input logic sub);
    case (f3)
      3'b000:  alu_sel = sub ? riscv_pkg::ALU_SUB : riscv_pkg::ALU_ADD;
      3'b001:  alu_sel = riscv_pkg::ALU_SLL;
      3'b010:  alu_sel = riscv_pkg::ALU_SLT;
      3'b100:  alu_sel = riscv_pkg::ALU_XOR;
      3'b101:  alu_sel = riscv_pkg::ALU_SRL;
      3'b110:  alu_sel = riscv_pkg::ALU_OR;
      default: alu_sel = riscv_pkg::ALU_AND;
    endcase
  endfunction

  assign inst   = i_fd.inst;
  assign funct3 = inst[14:12];
  assign size   = (funct3[1:0] == 2'b00) ? riscv_pkg::MEM_B :
                  (funct3[1:0] == 2'b10) ? riscv_pkg::MEM_W : riscv_pkg::MEM_D;

  always_comb begin
    ctrl    = '0;
    imm     = '0;
    known   = 1'b1;
    use_rs1 = 1'b0;
    use_rs2 = 1'b0;
    case (riscv_pkg::opcode_e'(inst[6:0]))
      riscv_pkg::OPC_LUI: begin
        ctrl.alu_op    = riscv_pkg::ALU_PASS_B;
        ctrl.b_sel_imm = 1'b1;
        ctrl.reg_write = 1'b1;
        imm = {{32{inst[31]}}, inst[31:12], 12'b0};
      end
      riscv_pkg::OPC_OP_IMM: begin
        ctrl.alu_op    = alu_sel(funct3, 1'b0);  // no subi
        ctrl.b_sel_imm = 1'b1;
        ctrl.reg_write = 1'b1;
        use_rs1 = 1'b1;
        imm = {{52{inst[31]}}, inst[31:20]};
      end
      riscv_pkg::OPC_OP: begin
        ctrl.alu_op    = alu_sel(funct3, inst[30]);
        ctrl.reg_write = 1'b1;
        use_rs1 = 1'b1;
        use_rs2 = 1'b1;
      end
      riscv_pkg::OPC_LOAD: begin
        ctrl.b_sel_imm     = 1'b1;
        ctrl.result_src    = riscv_pkg::RES_LOAD;
        ctrl.mem_read      = 1'b1;
        ctrl.mem_size      = size;
        ctrl.load_unsigned = funct3[2];
        ctrl.reg_write     = 1'b1;
        use_rs1 = 1'b1;
        imm = {{52{inst[31]}}, inst[31:20]};
      end
      riscv_pkg::OPC_STORE: begin
        ctrl.b_sel_imm = 1'b1;
        ctrl.mem_write = 1'b1;
        ctrl.mem_size  = size;
        use_rs1 = 1'b1;
        use_rs2 = 1'b1;
        imm = {{52{inst[31]}}, inst[31:25], inst[11:7]};
      end
      riscv_pkg::OPC_BRANCH: begin
        ctrl.branch = funct3[0] ? riscv_pkg::BR_NE : riscv_pkg::BR_EQ;
        use_rs1 = 1'b1;
        use_rs2 = 1'b1;
        imm = {{51{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
      end
      riscv_pkg::OPC_JAL: begin
        ctrl.jump       = 1'b1;
        ctrl.a_sel_pc   = 1'b1;
        ctrl.b_sel_imm  = 1'b1;
        ctrl.result_src = riscv_pkg::RES_PC4;  // rd gets the link address
        ctrl.reg_write  = 1'b1;
        imm = {{43{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
      end
      default: known = 1'b0;
    endcase
  end

  // unused source fields read as x0 so they never forward or stall
  assign o_rs1 = (i_fd.valid && use_rs1) ? inst[19:15] : '0;
  assign o_rs2 = (i_fd.valid && use_rs2) ? inst[24:20] : '0;

  always_ff @(posedge i_riscv_dstage_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      for (int i = 0; i < riscv_pkg::NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (i_wb_we && i_wb_rd != '0) begin
      regs[i_wb_rd] <= i_wb_data;
    end
  end

  always_comb begin
    o_de.valid = i_fd.valid && known;
    o_de.pc    = i_fd.pc;
    o_de.rs1   = o_rs1;
    o_de.rs2   = o_rs2;
    o_de.rd    = inst[11:7];
    o_de.imm   = imm;
    o_de.ctrl  = o_de.valid ? ctrl : '0;
    // write-through so writeback and decode can share a cycle
    o_de.rs1_data = (o_rs1 == '0) ? '0 :
                    (i_wb_we && i_wb_rd == o_rs1) ? i_wb_data : regs[o_rs1];
    o_de.rs2_data = (o_rs2 == '0) ? '0 :
                    (i_wb_we && i_wb_rd == o_rs2) ? i_wb_data : regs[o_rs2];
  end

endmodule

`default_nettype wire

/* hdl/riscv_estage.sv */
`timescale 1ns/100ps
`default_nettype none

module riscv_estage (
  input  wire riscv_pkg::de_t      i_de,
  input  wire riscv_pkg::fwd_sel_e i_fwd_a,
  input  wire riscv_pkg::fwd_sel_e i_fwd_b,
  input  wire riscv_pkg::xlen_t    i_m_result,
  input  wire riscv_pkg::xlen_t    i_w_result,
  output riscv_pkg::em_t           o_em,
  output logic                     o_redirect,
  output riscv_pkg::xlen_t         o_target
);

  riscv_pkg::xlen_t rs1_val, rs2_val;
  riscv_pkg::xlen_t op_a, op_b, alu_res;
  logic             equal, taken;

  // forwarded register operands
  always_comb begin
    case (i_fwd_a)
      riscv_pkg::FWD_MEM: rs1_val = i_m_result;
      riscv_pkg::FWD_WB:  rs1_val = i_w_result;
      default:            rs1_val = i_de.rs1_data;
    endcase
    case (i_fwd_b)
      riscv_pkg::FWD_MEM: rs2_val = i_m_result;
      riscv_pkg::FWD_WB:  rs2_val = i_w_result;
      default:            rs2_val = i_de.rs2_data;
    endcase
  end

  assign op_a = i_de.ctrl.a_sel_pc  ? i_de.pc  : rs1_val;
  assign op_b = i_de.ctrl.b_sel_imm ? i_de.imm : rs2_val;

  always_comb begin
    case (i_de.ctrl.alu_op)
      riscv_pkg::ALU_SUB:    alu_res = op_a - op_b;
      riscv_pkg::ALU_AND:    alu_res = op_a & op_b;
      riscv_pkg::ALU_OR:     alu_res = op_a | op_b;
      riscv_pkg::ALU_XOR:    alu_res = op_a ^ op_b;
      riscv_pkg::ALU_SLT:    alu_res = riscv_pkg::xlen_t'($signed(op_a) < $signed(op_b));
      riscv_pkg::ALU_SLL:    alu_res = op_a << op_b[5:0];  // rv64 shamt is 6 bits
      riscv_pkg::ALU_SRL:    alu_res = op_a >> op_b[5:0];
      riscv_pkg::ALU_PASS_B: alu_res = op_b;               // lui
      default:               alu_res = op_a + op_b;
    endcase
  end

  // branches compare the forwarded registers, not the alu operands
  assign equal = (rs1_val == rs2_val);

  always_comb begin
    case (i_de.ctrl.branch)
      riscv_pkg::BR_EQ: taken = equal;
      riscv_pkg::BR_NE: taken = !equal;
      default:          taken = 1'b0;
    endcase
  end

  assign o_target   = i_de.pc + i_de.imm;
  assign o_redirect = i_de.valid && (taken || i_de.ctrl.jump);

  always_comb begin
    o_em.valid      = i_de.valid;
    o_em.result     = alu_res;
    o_em.store_data = rs2_val;
    o_em.pc_plus4   = i_de.pc + riscv_pkg::xlen_t'(4);
    o_em.rd         = i_de.rd;
    o_em.ctrl       = i_de.ctrl;
  end

endmodule

`default_nettype wire

/* hdl/riscv_fstage.sv */
`timescale 1ns/100ps
`default_nettype none

module riscv_fstage (
  input  wire logic              i_riscv_fstage_clk,
  input  wire logic              i_arst_n,
  input  wire logic              i_stall,
  input  wire logic              i_redirect,
  input  wire riscv_pkg::xlen_t  i_target,
  input  wire riscv_pkg::inst_t  i_inst,
  output riscv_pkg::xlen_t       o_pc,
  output riscv_pkg::fd_t         o_fd
);

  riscv_pkg::xlen_t pc_next;

  always_comb begin
    if (i_redirect) begin
      pc_next = i_target;                          // taken branch or jal
    end else if (i_stall) begin
      pc_next = o_pc;
    end else begin
      pc_next = o_pc + riscv_pkg::xlen_t'(4);
    end
  end

  always_ff @(posedge i_riscv_fstage_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_pc <= riscv_pkg::RESET_PC;
    end else begin
      o_pc <= pc_next;
    end
  end

  assign o_fd = '{valid: 1'b1, pc: o_pc, inst: i_inst};

endmodule

`default_nettype wire

/* hdl/riscv_hazard.sv */
`timescale 1ns/100ps
`default_nettype none

module riscv_hazard (
  input  wire riscv_pkg::reg_addr_t i_d_rs1,
  input  wire riscv_pkg::reg_addr_t i_d_rs2,
  input  wire riscv_pkg::reg_addr_t i_e_rs1,
  input  wire riscv_pkg::reg_addr_t i_e_rs2,
  input  wire riscv_pkg::reg_addr_t i_e_rd,
  input  wire riscv_pkg::reg_addr_t i_m_rd,
  input  wire riscv_pkg::reg_addr_t i_w_rd,
  input  wire logic                 i_e_mem_read,
  input  wire logic                 i_m_reg_write,
  input  wire logic                 i_w_reg_write,
  input  wire logic                 i_redirect,
  output riscv_pkg::fwd_sel_e       o_fwd_a,
  output riscv_pkg::fwd_sel_e       o_fwd_b,
  output logic                      o_stall_f,
  output logic                      o_flush_fd,
  output logic                      o_flush_de
);

  logic load_use;

  // memory stage is younger so it wins over writeback
  function automatic riscv_pkg::fwd_sel_e fwd(input riscv_pkg::reg_addr_t rs);
    if (rs != '0 && i_m_reg_write && i_m_rd == rs) begin
      fwd = riscv_pkg::FWD_MEM;
    end else if (rs != '0 && i_w_reg_write && i_w_rd == rs) begin
      fwd = riscv_pkg::FWD_WB;
    end else begin
      fwd = riscv_pkg::FWD_RF;
    end
  endfunction

  assign o_fwd_a = fwd(i_e_rs1);
  assign o_fwd_b = fwd(i_e_rs2);

  // load data only exists after memory, so hold decode one cycle
  assign load_use = i_e_mem_read && (i_e_rd != '0) &&
                    ((i_e_rd == i_d_rs1) || (i_e_rd == i_d_rs2));

  assign o_stall_f  = load_use;
  assign o_flush_fd = i_redirect;
  assign o_flush_de = load_use || i_redirect;

endmodule

`default_nettype wire

/* hdl/riscv_pipe_reg.sv */
`timescale 1ns/100ps
`default_nettype none

module riscv_pipe_reg #(
  parameter type payload_t = riscv_pkg::fd_t
) (
  input  wire logic     i_riscv_pipe_reg_clk,
  input  wire logic     i_arst_n,
  input  wire logic     i_en,     // low holds the contents
  input  wire logic     i_flush,
  input  wire payload_t i_d,
  output payload_t      o_q
);

  // an all-zero payload is a bubble, valid and ctrl cleared
  always_ff @(posedge i_riscv_pipe_reg_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_q <= '0;
    end else if (i_flush) begin
      o_q <= '0;            // flush wins over stall
    end else if (i_en) begin
      o_q <= i_d;
    end
  end

endmodule

`default_nettype wire

/* hdl/riscv_pkg.sv */
`default_nettype none

package riscv_pkg;

  localparam int XLEN       = 64;
  localparam int INST_W     = 32;
  localparam int REG_ADDR_W = 5;
  localparam int NUM_REGS   = 32;
  localparam logic [XLEN-1:0] RESET_PC = '0;

  typedef logic [XLEN-1:0]       xlen_t;
  typedef logic [INST_W-1:0]     inst_t;
  typedef logic [REG_ADDR_W-1:0] reg_addr_t;

  // major opcodes of the supported subset
  typedef enum logic [6:0] {
    OPC_LUI    = 7'b0110111,
    OPC_OP_IMM = 7'b0010011,
    OPC_OP     = 7'b0110011,
    OPC_LOAD   = 7'b0000011,
    OPC_STORE  = 7'b0100011,
    OPC_BRANCH = 7'b1100011,
    OPC_JAL    = 7'b1101111
  } opcode_e;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
    ALU_SLT, ALU_SLL, ALU_SRL, ALU_PASS_B
  } alu_op_e;

  typedef enum logic [1:0] {RES_ALU, RES_LOAD, RES_PC4} result_src_e;

  // matches funct3[1:0] of loads and stores
  typedef enum logic [1:0] {MEM_B = 2'b00, MEM_W = 2'b10, MEM_D = 2'b11} mem_size_e;

  typedef enum logic [1:0] {BR_NONE, BR_EQ, BR_NE} branch_e;

  typedef enum logic [1:0] {FWD_RF, FWD_MEM, FWD_WB} fwd_sel_e;

  typedef struct packed {
    alu_op_e     alu_op;
    logic        a_sel_pc;       // operand a is the pc
    logic        b_sel_imm;      // operand b is the immediate
    result_src_e result_src;
    logic        mem_read;
    logic        mem_write;
    mem_size_e   mem_size;
    logic        load_unsigned;
    logic        reg_write;
    branch_e     branch;
    logic        jump;
  } ctrl_t;

  typedef struct packed {
    logic  valid;
    xlen_t pc;
    inst_t inst;
  } fd_t;

  typedef struct packed {
    logic      valid;
    xlen_t     pc;
    reg_addr_t rs1;
    reg_addr_t rs2;
    reg_addr_t rd;
    xlen_t     rs1_data;
    xlen_t     rs2_data;
    xlen_t     imm;
    ctrl_t     ctrl;
  } de_t;

  typedef struct packed {
    logic      valid;
    xlen_t     result;
    xlen_t     store_data;
    xlen_t     pc_plus4;
    reg_addr_t rd;
    ctrl_t     ctrl;
  } em_t;

  typedef struct packed {
    logic      valid;
    xlen_t     result;
    xlen_t     load_raw;     // whole doubleword from data memory
    logic [2:0] byte_off;
    xlen_t     pc_plus4;
    reg_addr_t rd;
    ctrl_t     ctrl;
  } mw_t;

endpackage

`default_nettype wire

/* hdl/riscv_wbstage.sv */
`timescale 1ns/100ps
`default_nettype none

module riscv_wbstage (
  input  wire riscv_pkg::mw_t  i_mw,
  output logic                 o_we,
  output riscv_pkg::reg_addr_t o_rd,
  output riscv_pkg::xlen_t     o_data
);

  riscv_pkg::xlen_t lane, load_val;

  assign lane = i_mw.load_raw >> {i_mw.byte_off, 3'b000};  // addressed byte to bit 0

  always_comb begin
    case (i_mw.ctrl.mem_size)
      riscv_pkg::MEM_B: load_val = i_mw.ctrl.load_unsigned ? {56'b0, lane[7:0]} :
                                                             {{56{lane[7]}}, lane[7:0]};
      riscv_pkg::MEM_W: load_val = i_mw.ctrl.load_unsigned ? {32'b0, lane[31:0]} :
                                                             {{32{lane[31]}}, lane[31:0]};
      default:          load_val = lane;
    endcase
  end

  always_comb begin
    case (i_mw.ctrl.result_src)
      riscv_pkg::RES_LOAD: o_data = load_val;
      riscv_pkg::RES_PC4:  o_data = i_mw.pc_plus4;
      default:             o_data = i_mw.result;
    endcase
  end

  assign o_rd = i_mw.rd;
  assign o_we = i_mw.valid && i_mw.ctrl.reg_write && (i_mw.rd != '0);

endmodule

`default_nettype wire
